// File: busArbiter.sv
// Two masters, one slave; grant is parked on the last owner so a lone master waits no cycle
`timescale 1ns/1ps
`default_nettype none

module busArbiter (
    input  wire logic            iClk,
    input  wire logic            rstN,
    input  wire pixelPkg::wbReqS fillReq,
    input  wire pixelPkg::wbReqS scanReq,
    input  wire pixelPkg::wbRspS slvRsp,
    output pixelPkg::wbRspS      fillRsp,
    output pixelPkg::wbRspS      scanRsp,
    output pixelPkg::wbReqS      slvReq
);

    // Last winner, also the current owner, 0 is fill
    logic       lastScan;
    // One-hot grant, bit 0 fill, bit 1 scan
    logic [1:0] grant;
    logic       ownerCyc;
    logic       otherCyc;

    assign grant = {lastScan, !lastScan};
    assign ownerCyc = lastScan ? scanReq.cyc : fillReq.cyc;
    assign otherCyc = lastScan ? fillReq.cyc : scanReq.cyc;

    // --------------------------------------------------
    // Round robin
    // --------------------------------------------------
    // Locked while owner holds cyc
    // A waiting master takes over in the owner's idle cycle
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
            lastScan <= 1'b0;
        else if (!ownerCyc && otherCyc)
            lastScan <= !lastScan;
    end

    // --------------------------------------------------
    // Request and response routing
    // --------------------------------------------------
    always_comb
    begin
        // Straight through under the registered grant
        slvReq = grant[1] ? scanReq : fillReq;
        // Read data shared, ack only to the owner
        fillRsp.dat = slvRsp.dat;
        fillRsp.ack = slvRsp.ack && grant[0];
        scanRsp.dat = slvRsp.dat;
        scanRsp.ack = slvRsp.ack && grant[1];
    end

endmodule

`default_nettype wire

// File: drawInput.txt
# F x0 y0 lastX lastY color = fill, decimal coordinates and hex RGB565 color
# S rnd = full scan with random pixReady when rnd is 1, E x y color = expected word after it
# C x0 y0 lastX lastY color rnd = fill with a scan started while the fill is busy
# Clear the whole frame first
F 0 0 15 7 0000
S 0
E 0 0 0000
E 15 7 0000
E 7 3 0000
# Single red rectangle
F 2 1 3 2 F800
S 0
E 2 1 F800
E 5 3 F800
E 6 3 0000
E 1 1 0000
E 2 4 0000
# Overlap, edge clipping and a fill fully outside the frame
F 4 2 3 3 07E0
F 12 5 7 7 001F
F 250 0 10 2 FFFF
S 0
E 4 2 07E0
E 3 2 F800
E 5 1 F800
E 7 5 07E0
E 12 5 001F
E 15 7 001F
E 11 5 0000
E 12 4 0000
E 0 0 0000
# Channel extremes and mixed values under back-pressure
F 0 6 0 0 FFFF
F 1 6 0 0 8410
F 2 6 0 0 F81F
F 3 6 0 0 0841
F 4 6 0 0 A554
S 1
E 0 6 FFFF
E 1 6 8410
E 2 6 F81F
E 3 6 0841
E 4 6 A554
E 5 6 0000
# Contention, then a second scan confirms the fill
C 8 0 3 1 1234 1
S 0
E 8 0 1234
E 11 1 1234
E 12 0 0000
E 7 0 0000
E 5 1 F800
C 0 7 15 0 4208 0
S 1
E 0 7 4208
E 15 7 4208
E 15 6 001F
E 4 5 07E0

// File: files.f
pixelPkg.sv
pixelDrawPosition.sv
rectFillMaster.sv
scanReadMaster.sv
busArbiter.sv
frameMemory.sv
pixelDrawTop.sv
pixelDrawBus_assertions.sv
tbPixelDraw.sv

// File: frameMemory.sv
// Single-port RAM of 2**(pHWidth+pVWidth) words; upper address bits ignored; contents not reset
`timescale 1ns/1ps
`default_nettype none

module frameMemory #(
    parameter int pHWidth = 4,
    parameter int pVWidth = 3
) (
    input  wire logic            iClk,
    input  wire logic            rstN,
    input  wire pixelPkg::wbReqS wbReq,
    output pixelPkg::wbRspS      wbRsp
);

    localparam int AdrBits = pHWidth + pVWidth;
    localparam int Depth = 2 ** AdrBits;

    logic [pixelPkg::DataWidth-1:0] mem [Depth];
    logic [pixelPkg::DataWidth-1:0] rdDat;
    logic [AdrBits-1:0]             wordAdr;
    logic                           ackQ;
    logic                           newStb;

    assign wordAdr = wbReq.adr[AdrBits-1:0];
    // Strobe not yet acked, a held stb after ack is no new transfer
    assign newStb = wbReq.cyc && wbReq.stb && !ackQ;

    // RAM array and read register
    always_ff @(posedge iClk)
    begin
        if (newStb && wbReq.we)
            mem[wordAdr] <= wbReq.dat;
        if (newStb && !wbReq.we)
            rdDat <= mem[wordAdr];
    end

    // One ack per strobe, one cycle later
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
            ackQ <= 1'b0;
        else
            ackQ <= newStb;
    end

    always_comb
    begin
        wbRsp.ack = ackQ;
        wbRsp.dat = rdDat;
    end

endmodule

`default_nettype wire

// File: pixelDrawBus_assertions.sv
// Bound into every busArbiter; checks only the master side and the grant, not the stream
`timescale 1ns/1ps
`default_nettype none

module pixelDrawBusAssertions (
    input wire logic            iClk,
    input wire logic            rstN,
    input wire pixelPkg::wbReqS fillReq,
    input wire pixelPkg::wbReqS scanReq,
    input wire pixelPkg::wbRspS fillRsp,
    input wire pixelPkg::wbRspS scanRsp,
    input wire logic [1:0]      grant
);

    // --------------------------------------------------
    // Wishbone classic master rules
    // --------------------------------------------------
    // Stb only inside cyc, and dropped the cycle after ack
    fillStbInCyc: assert property (@(posedge iClk) disable iff (!rstN)
        fillReq.stb |-> fillReq.cyc && !$past(fillRsp.ack))
        else $error("Fill master raised stb without cyc or held it past ack");

    scanStbInCyc: assert property (@(posedge iClk) disable iff (!rstN)
        scanReq.stb |-> scanReq.cyc && !$past(scanRsp.ack))
        else $error("Scan master raised stb without cyc or held it past ack");

    // Address held while the strobe waits for ack
    fillAdrHeld: assert property (@(posedge iClk) disable iff (!rstN)
        fillReq.stb && !fillRsp.ack |=> $stable(fillReq.adr))
        else $error("Fill master changed adr before ack");

    scanAdrHeld: assert property (@(posedge iClk) disable iff (!rstN)
        scanReq.stb && !scanRsp.ack |=> $stable(scanReq.adr))
        else $error("Scan master changed adr before ack");

    // --------------------------------------------------
    // Grant
    // --------------------------------------------------
    // Owner keeps the bus until it drops cyc
    grantHeldFill: assert property (@(posedge iClk) disable iff (!rstN)
        grant[0] && fillReq.cyc |=> grant[0])
        else $error("Grant taken from the fill master during its cycle");

    grantHeldScan: assert property (@(posedge iClk) disable iff (!rstN)
        grant[1] && scanReq.cyc |=> grant[1])
        else $error("Grant taken from the scan master during its cycle");

    // Ack only to a master with a strobe out
    ackToRequester: assert property (@(posedge iClk) disable iff (!rstN)
        (!fillRsp.ack || fillReq.stb) && (!scanRsp.ack || scanReq.stb))
        else $error("Ack routed to a master without a strobe");

endmodule

bind busArbiter pixelDrawBusAssertions uBusAssert (
    .iClk    (iClk),
    .rstN    (rstN),
    .fillReq (fillReq),
    .scanReq (scanReq),
    .fillRsp (fillRsp),
    .scanRsp (scanRsp),
    .grant   (grant)
);

`default_nettype wire

// File: pixelDrawPosition.sv
// Limits are inclusive last indices; clear wins over advance; areaEnd is combinational
`timescale 1ns/1ps
`default_nettype none

module pixelDrawPosition #(
    parameter int pHWidth = 4,
    parameter int pVWidth = 3
) (
    input  wire logic               iClk,
    input  wire logic               rstN,
    input  wire logic [pHWidth-1:0] hLast,
    input  wire logic [pVWidth-1:0] vLast,
    input  wire logic               clear,
    input  wire logic               advance,
    output logic      [pHWidth-1:0] hPos,
    output logic      [pVWidth-1:0] vPos,
    output logic                    areaEnd
);

    // Index at its limit
    logic hEnd;
    logic vEnd;

    assign hEnd = (hPos == hLast);
    assign vEnd = (vPos == vLast);
    // High while sitting on the last position
    assign areaEnd = hEnd && vEnd;

    // --------------------------------------------------
    // Horizontal index
    // --------------------------------------------------
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
            hPos <= '0;
        else if (clear)
            hPos <= '0;
        else if (advance)
            hPos <= hEnd ? '0 : hPos + 1'b1;
    end

    // --------------------------------------------------
    // Vertical index, steps on each horizontal wrap
    // --------------------------------------------------
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
            vPos <= '0;
        else if (clear)
            vPos <= '0;
        else if (advance && hEnd)
            // Back to the first line after the area end
            vPos <= vEnd ? '0 : vPos + 1'b1;
    end

endmodule

`default_nettype wire

// File: pixelDrawTop.sv
// Frame is 2**pHWidth by 2**pVWidth pixels; fill and scan share one RAM through the arbiter
`timescale 1ns/1ps
`default_nettype none

module pixelDrawTop #(
    parameter int pHWidth = 4,
    parameter int pVWidth = 3
) (
    input  wire logic              iClk,
    input  wire logic              rstN,
    input  wire logic              fillStart,
    input  wire pixelPkg::rectCmdS fillCmd,
    input  wire logic              scanStart,
    input  wire logic              pixReady,
    output logic                   fillBusy,
    output logic                   fillDone,
    output pixelPkg::pixelOutS     pixOut,
    output logic                   pixValid,
    output logic                   scanDone
);

    // Master side buses
    pixelPkg::wbReqS fillReq;
    pixelPkg::wbRspS fillRsp;
    pixelPkg::wbReqS scanReq;
    pixelPkg::wbRspS scanRsp;
    // Slave side bus
    pixelPkg::wbReqS slvReq;
    pixelPkg::wbRspS slvRsp;

    // --------------------------------------------------
    // Bus masters
    // --------------------------------------------------
    rectFillMaster #(
        .pHWidth (pHWidth),
        .pVWidth (pVWidth)
    ) uFill (
        .iClk      (iClk),
        .rstN      (rstN),
        .fillStart (fillStart),
        .fillCmd   (fillCmd),
        .wbRsp     (fillRsp),
        .wbReq     (fillReq),
        .fillBusy  (fillBusy),
        .fillDone  (fillDone)
    );

    scanReadMaster #(
        .pHWidth (pHWidth),
        .pVWidth (pVWidth)
    ) uScan (
        .iClk      (iClk),
        .rstN      (rstN),
        .scanStart (scanStart),
        .wbRsp     (scanRsp),
        .pixReady  (pixReady),
        .wbReq     (scanReq),
        .pixOut    (pixOut),
        .pixValid  (pixValid),
        .scanDone  (scanDone)
    );

    // --------------------------------------------------
    // Arbiter and frame RAM
    // --------------------------------------------------
    busArbiter uArb (
        .iClk    (iClk),
        .rstN    (rstN),
        .fillReq (fillReq),
        .scanReq (scanReq),
        .slvRsp  (slvRsp),
        .fillRsp (fillRsp),
        .scanRsp (scanRsp),
        .slvReq  (slvReq)
    );

    frameMemory #(
        .pHWidth (pHWidth),
        .pVWidth (pVWidth)
    ) uMem (
        .iClk  (iClk),
        .rstN  (rstN),
        .wbReq (slvReq),
        .wbRsp (slvRsp)
    );

endmodule

`default_nettype wire

// File: pixelPkg.sv
// Single Wishbone classic transfers only; one 16-bit word holds one RGB565 pixel
`default_nettype none

package pixelPkg;

    // Bus widths
    localparam int AdrWidth = 16;
    localparam int DataWidth = 16;

    // --------------------------------------------------
    // Wishbone classic request and response
    // --------------------------------------------------
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [AdrWidth-1:0]  adr;
        logic [DataWidth-1:0] dat;
    } wbReqS;

    typedef struct packed {
        logic                 ack;
        logic [DataWidth-1:0] dat;
    } wbRspS;

    // RGB565 field layout, red on top
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565S;

    // One pixel word, raw or split into channels
    typedef union packed {
        logic [DataWidth-1:0] raw;
        rgb565S               rgb;
    } pixelWordU;

    // Fill command, lastX and lastY are size minus one
    typedef struct packed {
        logic [7:0]           x0;
        logic [7:0]           y0;
        logic [7:0]           lastX;
        logic [7:0]           lastY;
        logic [DataWidth-1:0] color;
    } rectCmdS;

    // Streamed pixel, 8 bits per channel
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixelOutS;

endpackage

`default_nettype wire

// File: rectFillMaster.sv
// Writes outside the 2**pHWidth by 2**pVWidth frame are skipped; fillStart ignored while busy
`timescale 1ns/1ps
`default_nettype none

module rectFillMaster #(
    parameter int pHWidth = 4,
    parameter int pVWidth = 3
) (
    input  wire logic              iClk,
    input  wire logic              rstN,
    input  wire logic              fillStart,
    input  wire pixelPkg::rectCmdS fillCmd,
    input  wire pixelPkg::wbRspS   wbRsp,
    output pixelPkg::wbReqS        wbReq,
    output logic                   fillBusy,
    output logic                   fillDone
);

    // Offsets span the whole command range, clipping is done afterwards
    localparam int CoordWidth = 8;
    localparam int FrameW = 2 ** pHWidth;
    localparam int FrameH = 2 ** pVWidth;

    typedef enum logic [1:0] {stIdle, stIssue, stWait} fillStateE;

    fillStateE             state;
    pixelPkg::rectCmdS     cmdQ;
    pixelPkg::pixelWordU   colorWord;
    logic [CoordWidth-1:0] hOff;
    logic [CoordWidth-1:0] vOff;
    logic                  areaEnd;
    logic [CoordWidth:0]   absX;
    logic [CoordWidth:0]   absY;
    logic                  inFrame;
    logic                  posClear;
    logic                  posAdvance;

    // Latch command on accepted start
    always_ff @(posedge iClk)
    begin
        if (posClear)
            cmdQ <= fillCmd;
    end

    // --------------------------------------------------
    // Rectangle walk
    // --------------------------------------------------
    pixelDrawPosition #(
        .pHWidth (CoordWidth),
        .pVWidth (CoordWidth)
    ) uPos (
        .iClk    (iClk),
        .rstN    (rstN),
        .hLast   (cmdQ.lastX),
        .vLast   (cmdQ.lastY),
        .clear   (posClear),
        .advance (posAdvance),
        .hPos    (hOff),
        .vPos    (vOff),
        .areaEnd (areaEnd)
    );

    // Absolute position, one extra bit for carry past 255
    assign absX = {1'b0, cmdQ.x0} + {1'b0, hOff};
    assign absY = {1'b0, cmdQ.y0} + {1'b0, vOff};
    assign inFrame = (absX < (CoordWidth + 1)'(FrameW)) && (absY < (CoordWidth + 1)'(FrameH));

    assign posClear = (state == stIdle) && fillStart;
    // Step on write ack, or straight away for a clipped position
    assign posAdvance = ((state == stWait) && wbRsp.ack) || ((state == stIssue) && !inFrame);

    // --------------------------------------------------
    // Control FSM
    // --------------------------------------------------
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
        begin
            state <= stIdle;
            fillDone <= 1'b0;
        end
        else
        begin
            fillDone <= 1'b0;
            case (state)
                stIdle:
                    if (fillStart)
                        state <= stIssue;
                stIssue:
                    // Cyc low here, gives the arbiter its switch cycle
                    if (inFrame)
                        state <= stWait;
                    else if (areaEnd)
                    begin
                        state <= stIdle;
                        fillDone <= 1'b1;
                    end
                stWait:
                    if (wbRsp.ack)
                    begin
                        state <= areaEnd ? stIdle : stIssue;
                        fillDone <= areaEnd;
                    end
                default:
                    state <= stIdle;
            endcase
        end
    end

    assign fillBusy = (state != stIdle);

    // Adr steady during stWait, counter only moves after ack
    always_comb
    begin
        colorWord.raw = cmdQ.color;
        wbReq.cyc = (state == stWait);
        wbReq.stb = (state == stWait);
        wbReq.we = 1'b1;
        wbReq.adr = '0;
        wbReq.adr[pHWidth+pVWidth-1:0] = {absY[pVWidth-1:0], absX[pHWidth-1:0]};
        wbReq.dat = colorWord.raw;
    end

endmodule

`default_nettype wire

// File: scanReadMaster.sv
// Full-frame raster reads only; one read in flight, one held beat; scanStart ignored while busy
`timescale 1ns/1ps
`default_nettype none

module scanReadMaster #(
    parameter int pHWidth = 4,
    parameter int pVWidth = 3
) (
    input  wire logic            iClk,
    input  wire logic            rstN,
    input  wire logic            scanStart,
    input  wire pixelPkg::wbRspS wbRsp,
    input  wire logic            pixReady,
    output pixelPkg::wbReqS      wbReq,
    output pixelPkg::pixelOutS   pixOut,
    output logic                 pixValid,
    output logic                 scanDone
);

    typedef enum logic [1:0] {stIdle, stIssue, stWait, stDrain} scanStateE;

    scanStateE           state;
    logic [pHWidth-1:0]  hPos;
    logic [pVWidth-1:0]  vPos;
    logic                areaEnd;
    logic                posClear;
    logic                readAck;
    logic                beatFree;
    pixelPkg::pixelWordU rdWord;
    pixelPkg::pixelOutS  expanded;

    assign posClear = (state == stIdle) && scanStart;
    assign readAck = (state == stWait) && wbRsp.ack;
    // Holding register empty, or its beat leaves this cycle
    assign beatFree = !pixValid || pixReady;

    // Raster walk over the whole frame
    pixelDrawPosition #(
        .pHWidth (pHWidth),
        .pVWidth (pVWidth)
    ) uPos (
        .iClk    (iClk),
        .rstN    (rstN),
        .hLast   ({pHWidth{1'b1}}),
        .vLast   ({pVWidth{1'b1}}),
        .clear   (posClear),
        .advance (readAck),
        .hPos    (hPos),
        .vPos    (vPos),
        .areaEnd (areaEnd)
    );

    // --------------------------------------------------
    // RGB565 to 8-bit channels
    // --------------------------------------------------
    always_comb
    begin
        rdWord.raw = wbRsp.dat;
        // Top bits repeated into the low bits
        expanded.red = {rdWord.rgb.red, rdWord.rgb.red[4:2]};
        expanded.green = {rdWord.rgb.green, rdWord.rgb.green[5:4]};
        expanded.blue = {rdWord.rgb.blue, rdWord.rgb.blue[4:2]};
    end

    // Beat payload
    always_ff @(posedge iClk)
    begin
        if (readAck)
            pixOut <= expanded;
    end

    // Beat valid, load always finds the register empty
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
            pixValid <= 1'b0;
        else if (readAck)
            pixValid <= 1'b1;
        else if (pixReady)
            pixValid <= 1'b0;
    end

    // --------------------------------------------------
    // Control FSM
    // --------------------------------------------------
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
        begin
            state <= stIdle;
            scanDone <= 1'b0;
        end
        else
        begin
            scanDone <= 1'b0;
            case (state)
                stIdle:
                    if (scanStart)
                        state <= stIssue;
                stIssue:
                    // Back-pressure holds the next read here
                    if (beatFree)
                        state <= stWait;
                stWait:
                    if (wbRsp.ack)
                        state <= areaEnd ? stDrain : stIssue;
                stDrain:
                    // Done only once the last beat is taken
                    if (pixValid && pixReady)
                    begin
                        state <= stIdle;
                        scanDone <= 1'b1;
                    end
                default:
                    state <= stIdle;
            endcase
        end
    end

    always_comb
    begin
        wbReq.cyc = (state == stWait);
        wbReq.stb = (state == stWait);
        wbReq.we = 1'b0;
        wbReq.adr = '0;
        wbReq.adr[pHWidth+pVWidth-1:0] = {vPos, hPos};
        wbReq.dat = '0;
    end

endmodule

`default_nettype wire

// File: tbPixelDraw.sv
// Reads drawInput.txt from the project root; expects the default 16x8 frame of the DUT
`timescale 1ns/1ps
`default_nettype none

module tbPixelDraw;

    localparam int FrameW = 16;
    localparam int FrameH = 8;
    localparam int Pixels = FrameW * FrameH;
    // Cycles allowed for one fill or scan
    localparam int Timeout = 5000;

    logic               iClk;
    logic               rstN;
    logic               fillStart;
    pixelPkg::rectCmdS  fillCmd;
    logic               scanStart;
    logic               pixReady;
    logic               fillBusy;
    logic               fillDone;
    pixelPkg::pixelOutS pixOut;
    logic               pixValid;
    logic               scanDone;

    // Reference frame and beats of the last scan
    logic [15:0] model [Pixels];
    logic [23:0] scanned [Pixels];
    // Pixels of a fill that runs during a scan
    logic        pending [Pixels];
    logic [15:0] pendingColor;

    int                errors;
    int                checks;
    int                timeouts;
    int                fd;
    int                code;
    int                xVal;
    int                yVal;
    int                xLast;
    int                yLast;
    int                rndFlag;
    logic [15:0]       colorVal;
    logic [7:0]        op;
    logic [8*160-1:0]  lineBuf;
    pixelPkg::rectCmdS cmd;

    pixelDrawTop DUT (
        .iClk      (iClk),
        .rstN      (rstN),
        .fillStart (fillStart),
        .fillCmd   (fillCmd),
        .scanStart (scanStart),
        .pixReady  (pixReady),
        .fillBusy  (fillBusy),
        .fillDone  (fillDone),
        .pixOut    (pixOut),
        .pixValid  (pixValid),
        .scanDone  (scanDone)
    );

    // 4 ns clock
    always #2 iClk = ~iClk;

    // --------------------------------------------------
    // Reference helpers
    // --------------------------------------------------
    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("Fail %s got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    // Field count of one parsed stimulus line
    task automatic checkFields(input int got, input int want);
        if (got != want)
        begin
            errors++;
            $display("Stimulus line has %0d fields where %0d were expected", got, want);
        end
    endtask

    // RGB565 to 8 bits per channel, top bits copied below
    function automatic logic [23:0] expandPixel(input logic [15:0] raw);
        int r;
        int g;
        int b;
        r = raw[15:11];
        g = raw[10:5];
        b = raw[4:0];
        // Shift up, refill the low bits from the top
        r = (r << 3) | (r >> 2);
        g = (g << 2) | (g >> 4);
        b = (b << 3) | (b >> 2);
        return {r[7:0], g[7:0], b[7:0]};
    endfunction

    // Clipped rectangle into the model, or only marked as pending
    function automatic void applyFill(input pixelPkg::rectCmdS c, input logic markOnly);
        int ax;
        int ay;
        for (int dy = 0; dy <= int'(c.lastY); dy++)
            for (int dx = 0; dx <= int'(c.lastX); dx++)
            begin
                ax = int'(c.x0) + dx;
                ay = int'(c.y0) + dy;
                if (ax < FrameW && ay < FrameH)
                begin
                    if (markOnly)
                        pending[ay * FrameW + ax] = 1'b1;
                    else
                        model[ay * FrameW + ax] = c.color;
                end
            end
    endfunction

    // --------------------------------------------------
    // Drivers and stream monitor
    // --------------------------------------------------
    task automatic pulseStart(input logic isFill, input pixelPkg::rectCmdS c);
        @(posedge iClk);
        #1;
        if (isFill)
        begin
            fillCmd = c;
            fillStart = 1'b1;
        end
        else
            scanStart = 1'b1;
        @(posedge iClk);
        #1;
        fillStart = 1'b0;
        scanStart = 1'b0;
    endtask

    // One clock, sampled at the falling edge where outputs are settled
    task automatic clockCycle(input logic rnd, input logic fillActive, inout int fillDones,
                              inout int scanDones, inout int beats);
        logic [15:0] expWord;
        @(posedge iClk);
        #1;
        if (rnd)
            pixReady = ($urandom % 4) != 0;
        else
            pixReady = 1'b1;
        @(negedge iClk);
        if (fillDone)
            fillDones++;
        if (scanDone)
            scanDones++;
        // Busy from start up to the done pulse
        checkValue("fillBusy", fillBusy, fillActive && fillDones == 0);
        if (pixValid && pixReady)
        begin
            if (beats < Pixels)
            begin
                scanned[beats] = pixOut;
                expWord = model[beats];
                // Concurrent fill may land before or after the read
                if (pending[beats] && pixOut == expandPixel(pendingColor))
                    expWord = pendingColor;
                checkValue("pixOut", pixOut, expandPixel(expWord));
            end
            beats++;
        end
    endtask

    task automatic runOps(input logic doFill, input logic doScan, input logic rnd,
                          input pixelPkg::rectCmdS c);
        int cycles;
        int fillDones;
        int scanDones;
        int beats;
        cycles = 0;
        fillDones = 0;
        scanDones = 0;
        beats = 0;
        if (doFill)
            pulseStart(1'b1, c);
        if (doScan)
            pulseStart(1'b0, c);
        while (((doFill && fillDones == 0) || (doScan && scanDones == 0)) && cycles < Timeout)
        begin
            clockCycle(rnd, doFill, fillDones, scanDones, beats);
            cycles++;
        end
        if ((doFill && fillDones == 0) || (doScan && scanDones == 0))
        begin
            timeouts++;
            $display("Timeout while waiting for the fill or the scan to finish");
        end
        // Idle cycles catch a repeated done or a stray beat
        for (int i = 0; i < 4; i++)
            clockCycle(1'b0, doFill, fillDones, scanDones, beats);
        if (doFill)
            checkValue("fillDone count", fillDones, 1);
        if (doScan)
        begin
            checkValue("scanDone count", scanDones, 1);
            checkValue("beat count", beats, Pixels);
        end
        checkValue("fillBusy", fillBusy, 0);
        checkValue("pixValid", pixValid, 0);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial
    begin
        iClk = 1'b0;
        rstN = 1'b0;
        fillStart = 1'b0;
        fillCmd = '0;
        scanStart = 1'b0;
        pixReady = 1'b1;
        errors = 0;
        checks = 0;
        timeouts = 0;
        void'($urandom(13));
        foreach (model[i])
        begin
            model[i] = '0;
            scanned[i] = '0;
            pending[i] = 1'b0;
        end
        repeat (5) @(posedge iClk);
        #1;
        rstN = 1'b1;
        @(negedge iClk);
        checkValue("fillBusy", fillBusy, 0);
        checkValue("fillDone", fillDone, 0);
        checkValue("pixValid", pixValid, 0);
        checkValue("scanDone", scanDone, 0);

        fd = $fopen("drawInput.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("Could not open the stimulus file drawInput.txt");
        end
        else
        begin
            while ($fscanf(fd, " %c", op) == 1)
            begin
                if (op == "#")
                    code = $fgets(lineBuf, fd);
                else if (op == "F" || op == "C")
                begin
                    code = $fscanf(fd, " %d %d %d %d %h", xVal, yVal, xLast, yLast, colorVal);
                    checkFields(code, 5);
                    cmd.x0 = xVal[7:0];
                    cmd.y0 = yVal[7:0];
                    cmd.lastX = xLast[7:0];
                    cmd.lastY = yLast[7:0];
                    cmd.color = colorVal;
                    if (op == "F")
                    begin
                        runOps(1'b1, 1'b0, 1'b0, cmd);
                        applyFill(cmd, 1'b0);
                    end
                    else
                    begin
                        // Scan starts while this fill is busy
                        code = $fscanf(fd, " %d", rndFlag);
                        checkFields(code, 1);
                        pendingColor = cmd.color;
                        applyFill(cmd, 1'b1);
                        runOps(1'b1, 1'b1, rndFlag[0], cmd);
                        applyFill(cmd, 1'b0);
                        foreach (pending[i])
                            pending[i] = 1'b0;
                    end
                end
                else if (op == "S")
                begin
                    code = $fscanf(fd, " %d", rndFlag);
                    checkFields(code, 1);
                    runOps(1'b0, 1'b1, rndFlag[0], '0);
                end
                else if (op == "E")
                begin
                    code = $fscanf(fd, " %d %d %h", xVal, yVal, colorVal);
                    checkFields(code, 3);
                    checkValue("model word", model[yVal * FrameW + xVal], colorVal);
                    checkValue("scanned pixel", scanned[yVal * FrameW + xVal],
                               expandPixel(colorVal));
                end
                else
                begin
                    errors++;
                    $display("Unknown command letter in the stimulus file");
                end
            end
            $fclose(fd);
        end

        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
